//--- design/dma_cmd_pkg.sv
`default_nettype none

package dma_cmd_pkg;

  // data and address widths of the two memory ports
  localparam int unsigned WordWidth     = 32;
  localparam int unsigned NicAddrWidth  = 32;
  localparam int unsigned HostAddrWidth = 64;

  // command fields
  localparam int unsigned LenWidth   = 16;
  localparam int unsigned CmdIdWidth = 8;

  // each response FIFO holds this many command ids
  localparam int unsigned RespFifoDepth = 4;
  localparam int unsigned RespPtrWidth  = $clog2(RespFifoDepth);

  // counts from 0 up to RespFifoDepth inclusive
  localparam int unsigned CntWidth = RespPtrWidth + 1;

  // one data word
  typedef logic [WordWidth-1:0] word_t;

  // word address on the NHI side
  typedef logic [NicAddrWidth-1:0] nic_addr_t;

  // word address on the host side, also the internal descriptor address
  typedef logic [HostAddrWidth-1:0] host_addr_t;

  // transfer length in words
  typedef logic [LenWidth-1:0] len_t;

  // id handed back with the response strobe
  typedef logic [CmdIdWidth-1:0] cmd_id_t;

  // completion counter and FIFO fill level
  typedef logic [CntWidth-1:0] cnt_t;

  // read/write pointer into a response FIFO
  typedef logic [RespPtrWidth-1:0] fifo_ptr_t;

  // copy channel states
  typedef enum logic [1:0] {
    CH_IDLE  = 2'd0,
    CH_READ  = 2'd1,
    CH_WRITE = 2'd2
  } chan_state_e;

endpackage

`default_nettype wire

//--- design/resp_id_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module resp_id_fifo
  import dma_cmd_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    push_i,
  input  cmd_id_t data_i,
  input  logic    pop_i,
  output cmd_id_t data_o,
  output logic    full_o
);

  cmd_id_t   mem_q [RespFifoDepth];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  cnt_t      count_q;

  // the head entry is always visible
  assign data_o = mem_q[rd_ptr_q];
  assign full_o = (count_q == cnt_t'(RespFifoDepth));

  // storage, written only on a push
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the level unchanged
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/resp_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module resp_arbiter
  import dma_cmd_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    rx_avail_i,
  input  logic    tx_avail_i,
  input  cmd_id_t rx_id_i,
  input  cmd_id_t tx_id_i,
  output logic    rx_pop_o,
  output logic    tx_pop_o,
  output logic    resp_valid_o,
  output cmd_id_t resp_id_o
);

  // set when the last grant went to tx, so rx wins the first tie
  logic    last_tx_q;
  logic    resp_valid_q;
  cmd_id_t resp_id_q;

  assign rx_pop_o = rx_avail_i && (!tx_avail_i || last_tx_q);
  assign tx_pop_o = tx_avail_i && !rx_pop_o;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      last_tx_q    <= 1'b1;
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= rx_pop_o || tx_pop_o;
      if (rx_pop_o || tx_pop_o) begin
        last_tx_q <= tx_pop_o;
      end
    end
  end

  // id of the popped head, qualified by the valid strobe
  always_ff @(posedge clk_i) begin
    resp_id_q <= rx_pop_o ? rx_id_i : tx_id_i;
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_id_o    = resp_id_q;

endmodule

`default_nettype wire

//--- design/copy_channel.sv
`timescale 1ns/1ps
`default_nettype none

module copy_channel
  import dma_cmd_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // descriptor from the front end
  input  logic       desc_valid_i,
  input  host_addr_t src_addr_i,
  input  host_addr_t dst_addr_i,
  input  len_t       len_i,
  output logic       idle_o,

  // source port, data arrives one cycle after rd_o
  output logic       rd_o,
  output host_addr_t rd_addr_o,
  input  word_t      rd_data_i,

  // destination port
  output logic       wr_o,
  output host_addr_t wr_addr_o,
  output word_t      wr_data_o,

  output logic       done_o
);

  chan_state_e state_q;
  host_addr_t  src_q;
  host_addr_t  dst_q;
  len_t        remain_q;
  len_t        offset_q;
  logic        done_q;
  host_addr_t  offset_ext;
  logic        accept;

  assign accept     = (state_q == CH_IDLE) && desc_valid_i;
  assign offset_ext = {{(HostAddrWidth-LenWidth){1'b0}}, offset_q};

  // descriptor addresses are held for the whole copy
  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_q <= src_addr_i;
      dst_q <= dst_addr_i;
    end
  end

  // one read and one write per word, alternating
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= CH_IDLE;
      remain_q <= '0;
      offset_q <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        CH_IDLE: begin
          if (desc_valid_i) begin
            remain_q <= len_i;
            offset_q <= '0;
            // an empty copy completes right away
            if (len_i == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= CH_READ;
            end
          end
        end
        CH_READ: begin
          state_q <= CH_WRITE;
        end
        CH_WRITE: begin
          offset_q <= offset_q + 1'b1;
          remain_q <= remain_q - 1'b1;
          if (remain_q == len_t'(1)) begin
            state_q <= CH_IDLE;
            done_q  <= 1'b1;
          end else begin
            state_q <= CH_READ;
          end
        end
        default: begin
          state_q <= CH_IDLE;
        end
      endcase
    end
  end

  assign idle_o = (state_q == CH_IDLE);

  assign rd_o      = (state_q == CH_READ);
  assign rd_addr_o = src_q + offset_ext;

  // the returned word is written in the cycle it arrives
  assign wr_o      = (state_q == CH_WRITE);
  assign wr_addr_o = dst_q + offset_ext;
  assign wr_data_o = rd_data_i;

  assign done_o = done_q;

endmodule

`default_nettype wire

//--- design/dma_cmd_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module dma_cmd_frontend
  import dma_cmd_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // command handshake
  input  logic       cmd_req_valid_i,
  output logic       cmd_req_ready_o,
  input  logic       nic_to_host_i,
  input  nic_addr_t  nic_addr_i,
  input  host_addr_t host_addr_i,
  input  len_t       length_i,
  input  cmd_id_t    cmd_id_i,

  // channel status
  input  logic       rx_idle_i,
  input  logic       tx_idle_i,
  input  logic       rx_done_i,
  input  logic       tx_done_i,

  // shared descriptor, steered by the two valid strobes
  output logic       rx_desc_valid_o,
  output logic       tx_desc_valid_o,
  output host_addr_t src_addr_o,
  output host_addr_t dst_addr_o,
  output len_t       len_o,

  // response
  output logic       cmd_resp_valid_o,
  output cmd_id_t    cmd_resp_id_o
);

  host_addr_t nic_addr_ext;
  logic       cmd_fire;
  logic       rx_full;
  logic       tx_full;
  logic       rx_pop;
  logic       tx_pop;
  cmd_id_t    rx_head_id;
  cmd_id_t    tx_head_id;
  cnt_t       rx_cnt_q;
  cnt_t       tx_cnt_q;

  assign nic_addr_ext = {{(HostAddrWidth-NicAddrWidth){1'b0}}, nic_addr_i};

  // rx copies NIC to host, tx copies host to NIC
  assign src_addr_o = nic_to_host_i ? nic_addr_ext : host_addr_i;
  assign dst_addr_o = nic_to_host_i ? host_addr_i : nic_addr_ext;
  assign len_o      = length_i;

  // accept only when the target channel and its id FIFO have room
  assign cmd_req_ready_o = nic_to_host_i ? (rx_idle_i && !rx_full)
                                         : (tx_idle_i && !tx_full);
  assign cmd_fire        = cmd_req_valid_i && cmd_req_ready_o;

  assign rx_desc_valid_o = cmd_fire && nic_to_host_i;
  assign tx_desc_valid_o = cmd_fire && !nic_to_host_i;

  resp_id_fifo i_rx_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (rx_desc_valid_o),
    .data_i (cmd_id_i),
    .pop_i  (rx_pop),
    .data_o (rx_head_id),
    .full_o (rx_full)
  );

  resp_id_fifo i_tx_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (tx_desc_valid_o),
    .data_i (cmd_id_i),
    .pop_i  (tx_pop),
    .data_o (tx_head_id),
    .full_o (tx_full)
  );

  // completed copies whose id has not been reported yet
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rx_cnt_q <= '0;
      tx_cnt_q <= '0;
    end else begin
      rx_cnt_q <= rx_cnt_q + cnt_t'(rx_done_i) - cnt_t'(rx_pop);
      tx_cnt_q <= tx_cnt_q + cnt_t'(tx_done_i) - cnt_t'(tx_pop);
    end
  end

  resp_arbiter i_resp_arb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rx_avail_i   (rx_cnt_q != '0),
    .tx_avail_i   (tx_cnt_q != '0),
    .rx_id_i      (rx_head_id),
    .tx_id_i      (tx_head_id),
    .rx_pop_o     (rx_pop),
    .tx_pop_o     (tx_pop),
    .resp_valid_o (cmd_resp_valid_o),
    .resp_id_o    (cmd_resp_id_o)
  );

endmodule

`default_nettype wire

//--- design/soc_dma_wrap.sv
`timescale 1ns/1ps
`default_nettype none

module soc_dma_wrap
  import dma_cmd_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // command
  input  logic       cmd_req_valid_i,
  output logic       cmd_req_ready_o,
  input  logic       nic_to_host_i,
  input  nic_addr_t  nic_addr_i,
  input  host_addr_t host_addr_i,
  input  len_t       length_i,
  input  cmd_id_t    cmd_id_i,

  // response
  output logic       cmd_resp_valid_o,
  output cmd_id_t    cmd_resp_id_o,

  // NHI memory port
  output logic       nhi_rd_o,
  output nic_addr_t  nhi_rd_addr_o,
  input  word_t      nhi_rd_data_i,
  output logic       nhi_wr_o,
  output nic_addr_t  nhi_wr_addr_o,
  output word_t      nhi_wr_data_o,

  // host memory port
  output logic       host_rd_o,
  output host_addr_t host_rd_addr_o,
  input  word_t      host_rd_data_i,
  output logic       host_wr_o,
  output host_addr_t host_wr_addr_o,
  output word_t      host_wr_data_o
);

  logic       rx_desc_valid;
  logic       tx_desc_valid;
  host_addr_t desc_src;
  host_addr_t desc_dst;
  len_t       desc_len;
  logic       rx_idle;
  logic       tx_idle;
  logic       rx_done;
  logic       tx_done;
  host_addr_t rx_rd_addr;
  host_addr_t tx_wr_addr;

  // the NHI port only sees the lower 32 address bits
  assign nhi_rd_addr_o = rx_rd_addr[NicAddrWidth-1:0];
  assign nhi_wr_addr_o = tx_wr_addr[NicAddrWidth-1:0];

  dma_cmd_frontend i_frontend (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_req_valid_i  (cmd_req_valid_i),
    .cmd_req_ready_o  (cmd_req_ready_o),
    .nic_to_host_i    (nic_to_host_i),
    .nic_addr_i       (nic_addr_i),
    .host_addr_i      (host_addr_i),
    .length_i         (length_i),
    .cmd_id_i         (cmd_id_i),
    .rx_idle_i        (rx_idle),
    .tx_idle_i        (tx_idle),
    .rx_done_i        (rx_done),
    .tx_done_i        (tx_done),
    .rx_desc_valid_o  (rx_desc_valid),
    .tx_desc_valid_o  (tx_desc_valid),
    .src_addr_o       (desc_src),
    .dst_addr_o       (desc_dst),
    .len_o            (desc_len),
    .cmd_resp_valid_o (cmd_resp_valid_o),
    .cmd_resp_id_o    (cmd_resp_id_o)
  );

  // reads NHI, writes host
  copy_channel i_rx_chan (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .desc_valid_i (rx_desc_valid),
    .src_addr_i   (desc_src),
    .dst_addr_i   (desc_dst),
    .len_i        (desc_len),
    .idle_o       (rx_idle),
    .rd_o         (nhi_rd_o),
    .rd_addr_o    (rx_rd_addr),
    .rd_data_i    (nhi_rd_data_i),
    .wr_o         (host_wr_o),
    .wr_addr_o    (host_wr_addr_o),
    .wr_data_o    (host_wr_data_o),
    .done_o       (rx_done)
  );

  // reads host, writes NHI
  copy_channel i_tx_chan (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .desc_valid_i (tx_desc_valid),
    .src_addr_i   (desc_src),
    .dst_addr_i   (desc_dst),
    .len_i        (desc_len),
    .idle_o       (tx_idle),
    .rd_o         (host_rd_o),
    .rd_addr_o    (host_rd_addr_o),
    .rd_data_i    (host_rd_data_i),
    .wr_o         (nhi_wr_o),
    .wr_addr_o    (tx_wr_addr),
    .wr_data_o    (nhi_wr_data_o),
    .done_o       (tx_done)
  );

endmodule

`default_nettype wire

//--- sim/tb_soc_dma_wrap.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_dma_wrap
  import dma_cmd_pkg::*;
;

  // lengths of the seven commands, shared with the watchdog budget
  localparam int unsigned NumCmds = 7;
  localparam int unsigned CmdLens [NumCmds] = '{8, 6, 5, 7, 4, 3, 0};

  logic       clk_i;
  logic       rst_ni;
  logic       cmd_req_valid_i;
  logic       cmd_req_ready_o;
  logic       nic_to_host_i;
  nic_addr_t  nic_addr_i;
  host_addr_t host_addr_i;
  len_t       length_i;
  cmd_id_t    cmd_id_i;
  logic       cmd_resp_valid_o;
  cmd_id_t    cmd_resp_id_o;
  logic       nhi_rd_o;
  nic_addr_t  nhi_rd_addr_o;
  word_t      nhi_rd_data_i;
  logic       nhi_wr_o;
  nic_addr_t  nhi_wr_addr_o;
  word_t      nhi_wr_data_o;
  logic       host_rd_o;
  host_addr_t host_rd_addr_o;
  word_t      host_rd_data_i;
  logic       host_wr_o;
  host_addr_t host_wr_addr_o;
  word_t      host_wr_data_o;

  // memory models and scoreboard
  word_t       nhi_mem [nic_addr_t];
  word_t       host_mem [host_addr_t];
  cmd_id_t     rx_exp [$];
  cmd_id_t     tx_exp [$];
  host_addr_t  host_rd_base;
  host_addr_t  host_rd_idx;
  int unsigned strobe_cnt;
  logic [15:0] lfsr_q;

  soc_dma_wrap i_dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_req_valid_i  (cmd_req_valid_i),
    .cmd_req_ready_o  (cmd_req_ready_o),
    .nic_to_host_i    (nic_to_host_i),
    .nic_addr_i       (nic_addr_i),
    .host_addr_i      (host_addr_i),
    .length_i         (length_i),
    .cmd_id_i         (cmd_id_i),
    .cmd_resp_valid_o (cmd_resp_valid_o),
    .cmd_resp_id_o    (cmd_resp_id_o),
    .nhi_rd_o         (nhi_rd_o),
    .nhi_rd_addr_o    (nhi_rd_addr_o),
    .nhi_rd_data_i    (nhi_rd_data_i),
    .nhi_wr_o         (nhi_wr_o),
    .nhi_wr_addr_o    (nhi_wr_addr_o),
    .nhi_wr_data_o    (nhi_wr_data_o),
    .host_rd_o        (host_rd_o),
    .host_rd_addr_o   (host_rd_addr_o),
    .host_rd_data_i   (host_rd_data_i),
    .host_wr_o        (host_wr_o),
    .host_wr_addr_o   (host_wr_addr_o),
    .host_wr_data_o   (host_wr_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t got);
    if (got !== exp) begin
      report_failure($sformatf("error %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic check_id(input string name, input cmd_id_t exp, input cmd_id_t got);
    if (got !== exp) begin
      report_failure($sformatf("error %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic check_host_addr(input string name, input host_addr_t exp,
                                 input host_addr_t got);
    if (got !== exp) begin
      report_failure($sformatf("error %s expected %h got %h", name, exp, got));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(output word_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w      = {w[30:0], lfsr_q[0]};
    end
  endtask

  // unwritten locations read back a pattern of the full address
  function automatic word_t fill_word(input host_addr_t a);
    return a[31:0] ^ a[63:32] ^ 32'h5a5a_c3c3;
  endfunction

  function automatic word_t nhi_read(input nic_addr_t a);
    return nhi_mem.exists(a) ? nhi_mem[a] : fill_word({32'h0, a});
  endfunction

  function automatic word_t host_read(input host_addr_t a);
    return host_mem.exists(a) ? host_mem[a] : fill_word(a);
  endfunction

  // read data arrives in the cycle after the strobe
  always begin : mem_model
    logic       nhi_hit;
    logic       host_hit;
    nic_addr_t  nhi_addr;
    host_addr_t host_addr;
    @(posedge clk_i);
    nhi_hit   = nhi_rd_o;
    host_hit  = host_rd_o;
    nhi_addr  = nhi_rd_addr_o;
    host_addr = host_rd_addr_o;
    strobe_cnt = strobe_cnt + int'(nhi_rd_o) + int'(nhi_wr_o)
               + int'(host_rd_o) + int'(host_wr_o);
    if (host_hit) begin
      check_host_addr("host_rd_addr_o", host_rd_base + host_rd_idx, host_addr);
      host_rd_idx = host_rd_idx + 64'd1;
    end
    if (nhi_wr_o) begin
      nhi_mem[nhi_wr_addr_o] = nhi_wr_data_o;
    end
    if (host_wr_o) begin
      host_mem[host_wr_addr_o] = host_wr_data_o;
    end
    #10;
    if (nhi_hit) begin
      nhi_rd_data_i = nhi_read(nhi_addr);
    end
    if (host_hit) begin
      host_rd_data_i = host_read(host_addr);
    end
  end

  // each direction keeps its own order, arbitration may interleave them
  always @(posedge clk_i) begin
    if (rst_ni && cmd_resp_valid_o) begin
      if (rx_exp.size() == 0 && tx_exp.size() == 0) begin
        report_failure("response strobe with no command outstanding");
      end else if (rx_exp.size() != 0 && cmd_resp_id_o == rx_exp[0]) begin
        void'(rx_exp.pop_front());
      end else if (tx_exp.size() != 0) begin
        check_id("cmd_resp_id_o", tx_exp[0], cmd_resp_id_o);
        void'(tx_exp.pop_front());
      end else begin
        check_id("cmd_resp_id_o", rx_exp[0], cmd_resp_id_o);
      end
    end
  end

  function automatic int unsigned watchdog_cycles();
    int unsigned sum;
    sum = 10;
    for (int i = 0; i < NumCmds; i++) begin
      sum = sum + 2 * CmdLens[i] + 20;
    end
    return sum;
  endfunction

  initial begin : watchdog
    #(watchdog_cycles() * 100);
    report_failure("timeout: responses missing");
  end

  task automatic fill_nhi(input nic_addr_t base, input int unsigned len);
    word_t w;
    for (int unsigned i = 0; i < len; i++) begin
      random_word(w);
      nhi_mem[base + nic_addr_t'(i)] = w;
    end
  endtask

  task automatic fill_host(input host_addr_t base, input int unsigned len);
    word_t w;
    for (int unsigned i = 0; i < len; i++) begin
      random_word(w);
      host_mem[base + host_addr_t'(i)] = w;
    end
  endtask

  // starts and ends 10 ns after a rising edge, stalls counts edges with ready low
  task automatic send_cmd(input logic to_host, input nic_addr_t nic, input host_addr_t host,
                          input int unsigned len, input cmd_id_t id,
                          output int unsigned stalls);
    stalls          = 0;
    cmd_req_valid_i = 1'b1;
    nic_to_host_i   = to_host;
    nic_addr_i      = nic;
    host_addr_i     = host;
    length_i        = len_t'(len);
    cmd_id_i        = id;
    @(posedge clk_i);
    while (!cmd_req_ready_o) begin
      stalls = stalls + 1;
      @(posedge clk_i);
    end
    if (to_host) begin
      rx_exp.push_back(id);
    end else begin
      tx_exp.push_back(id);
      host_rd_base = host;
      host_rd_idx  = '0;
    end
    #10;
    cmd_req_valid_i = 1'b0;
  endtask

  task automatic wait_responses();
    while (rx_exp.size() != 0 || tx_exp.size() != 0) begin
      @(posedge clk_i);
      #10;
    end
  endtask

  task automatic check_rx_copy(input nic_addr_t nic, input host_addr_t host,
                               input int unsigned len);
    for (int unsigned i = 0; i < len; i++) begin
      check_word("host_wr_data_o", nhi_read(nic + nic_addr_t'(i)),
                 host_read(host + host_addr_t'(i)));
    end
  endtask

  task automatic check_tx_copy(input host_addr_t host, input nic_addr_t nic,
                               input int unsigned len);
    for (int unsigned i = 0; i < len; i++) begin
      check_word("nhi_wr_data_o", host_read(host + host_addr_t'(i)),
                 nhi_read(nic + nic_addr_t'(i)));
    end
  endtask

  task automatic test_nic_to_host();
    int unsigned stalls;
    fill_nhi(32'h0000_0100, CmdLens[0]);
    send_cmd(1'b1, 32'h0000_0100, 64'h0000_0000_2000_0000, CmdLens[0], 8'h11, stalls);
    wait_responses();
    check_rx_copy(32'h0000_0100, 64'h0000_0000_2000_0000, CmdLens[0]);
  endtask

  // upper host address bits are nonzero here
  task automatic test_host_to_nic();
    int unsigned stalls;
    fill_host(64'h0000_0001_8000_0040, CmdLens[1]);
    send_cmd(1'b0, 32'h0000_0400, 64'h0000_0001_8000_0040, CmdLens[1], 8'h22, stalls);
    wait_responses();
    check_tx_copy(64'h0000_0001_8000_0040, 32'h0000_0400, CmdLens[1]);
  endtask

  task automatic test_both_directions();
    int unsigned stalls;
    fill_nhi(32'h0000_0200, CmdLens[2]);
    fill_host(64'h0000_00ff_0000_1000, CmdLens[3]);
    send_cmd(1'b1, 32'h0000_0200, 64'h0000_0000_3000_0000, CmdLens[2], 8'h33, stalls);
    send_cmd(1'b0, 32'h0000_0800, 64'h0000_00ff_0000_1000, CmdLens[3], 8'h34, stalls);
    wait_responses();
    check_rx_copy(32'h0000_0200, 64'h0000_0000_3000_0000, CmdLens[2]);
    check_tx_copy(64'h0000_00ff_0000_1000, 32'h0000_0800, CmdLens[3]);
  endtask

  // second rx command must wait 2n edges for the first copy to finish
  task automatic test_back_pressure();
    int unsigned stalls;
    fill_nhi(32'h0000_0300, CmdLens[4]);
    fill_nhi(32'h0000_0380, CmdLens[5]);
    send_cmd(1'b1, 32'h0000_0300, 64'h0000_0000_4000_0000, CmdLens[4], 8'h41, stalls);
    send_cmd(1'b1, 32'h0000_0380, 64'h0000_0000_4000_1000, CmdLens[5], 8'h42, stalls);
    if (stalls < 2 * CmdLens[4]) begin
      report_failure("second rx command accepted while the rx channel was busy");
    end
    if (stalls > 2 * CmdLens[4]) begin
      report_failure("cmd_req_ready_o stayed low after the first rx copy finished");
    end
    wait_responses();
    check_rx_copy(32'h0000_0300, 64'h0000_0000_4000_0000, CmdLens[4]);
    check_rx_copy(32'h0000_0380, 64'h0000_0000_4000_1000, CmdLens[5]);
  endtask

  task automatic test_zero_length();
    int unsigned stalls;
    int unsigned strobes_before;
    strobes_before = strobe_cnt;
    send_cmd(1'b1, 32'h0000_0900, 64'h0000_0000_5000_0000, CmdLens[6], 8'h50, stalls);
    wait_responses();
    if (strobe_cnt != strobes_before) begin
      report_failure("memory strobe seen during a zero-length copy");
    end
  endtask

  initial begin : main
    rst_ni          = 1'b0;
    cmd_req_valid_i = 1'b0;
    nic_to_host_i   = 1'b0;
    nic_addr_i      = '0;
    host_addr_i     = '0;
    length_i        = '0;
    cmd_id_i        = '0;
    nhi_rd_data_i   = '0;
    host_rd_data_i  = '0;
    host_rd_base    = '0;
    host_rd_idx     = '0;
    strobe_cnt      = 0;
    lfsr_q          = 16'd50;
    repeat (8) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    test_nic_to_host();
    test_host_to_nic();
    test_both_directions();
    test_back_pressure();
    test_zero_length();
    // a few idle cycles so a stray response would still be caught
    repeat (4) @(posedge clk_i);
    if (rx_exp.size() == 0 && tx_exp.size() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      report_failure("responses still outstanding at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- compile.f
design/dma_cmd_pkg.sv
design/resp_id_fifo.sv
design/resp_arbiter.sv
design/copy_channel.sv
design/dma_cmd_frontend.sv
design/soc_dma_wrap.sv
sim/tb_soc_dma_wrap.sv

//--- Makefile
TOP := tb_soc_dma_wrap

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module soc_dma_wrap \
		design/dma_cmd_pkg.sv design/resp_id_fifo.sv design/resp_arbiter.sv \
		design/copy_channel.sv design/dma_cmd_frontend.sv design/soc_dma_wrap.sv

sim:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		-f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
